/* rtl/ic_pkg.sv */
// Instruction cache package holding the cache geometry, address fields and shared types
`default_nettype none

package ic_pkg;

   localparam int ADDR_W       = 16;
   localparam int P_LINE       = 4;                    // 16-byte lines
   localparam int P_SETS       = 4;
   localparam int NUM_WAYS     = 2;
   localparam int P_WIN_BYTES  = 3;                    // Two instructions per fetch
   localparam int WIN_W        = 8 << P_WIN_BYTES;
   localparam int BUS_W        = 32;
   localparam int BEATS        = (1 << P_LINE) / (BUS_W / 8);
   localparam int WIN_PER_LINE = 1 << (P_LINE - P_WIN_BYTES);

   // Address split is tag | set | window | byte
   localparam int TAG_W        = ADDR_W - P_SETS - P_LINE;
   localparam int PAY_AW       = P_SETS + P_LINE - P_WIN_BYTES;
   localparam int BEAT_W       = $clog2(BEATS);
   localparam int WIN_IDX_W    = $clog2(WIN_PER_LINE);

   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [P_SETS-1:0]   set_t;
   typedef logic [ADDR_W-1:0]   paddr_t;
   typedef logic [WIN_W-1:0]    win_t;
   typedef logic [NUM_WAYS-1:0] way_vec_t;

   typedef struct packed {
      tag_t tag;
      logic valid;
   } tag_entry_t;

   typedef enum logic [2:0] {
      BOOT,
      IDLE,
      REPLACE,
      REFILL,
      INVALIDATE,
      RELOAD
   } ic_state_t;

endpackage

`default_nettype wire

/* rtl/ic_ram.sv */
// Single-port RAM with registered read that keeps its last output while not enabled
`default_nettype none

module ic_ram
#(
   parameter type data_t = logic [31:0],
   parameter int  AW     = 4
)
(
   input  wire logic          clk,
   input  wire logic          i_re,
   input  wire logic          i_we,
   input  wire logic [AW-1:0] i_addr,
   input  wire data_t         i_wdata,
   output data_t              o_rdata
);

   data_t mem [0:(1<<AW)-1];

   always_ff @(posedge clk)
      begin
         if (i_we)
            mem[i_addr] <= i_wdata;
         // Output only moves on an enabled read
         if (i_re)
            o_rdata <= mem[i_addr];
      end

endmodule

`default_nettype wire

/* rtl/ic_lookup.sv */
// Instruction cache lookup with stage registers, way compare and output window register
`default_nettype none

module ic_lookup
   import ic_pkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      i_rst_n,
   input  wire logic                      i_ce,
   input  wire paddr_t                    i_addr,
   input  wire tag_entry_t [NUM_WAYS-1:0] i_tags,
   input  wire win_t [NUM_WAYS-1:0]       i_windows,
   input  wire logic                      i_refilling,
   input  wire logic                      i_win_we,
   input  wire logic [WIN_IDX_W-1:0]      i_win_idx,
   input  wire win_t                      i_win,
   output logic                           o_s1_valid,
   output logic                           o_hit,
   output paddr_t                         o_s2_addr,
   output win_t                           o_ins,
   output logic                           o_valid
);

   paddr_t   s1_addr;         // Address whose RAM data is on the outputs
   logic     s2_valid;
   way_vec_t hit_vec;
   win_t     match_win;
   logic     win_get;

   // Both stages advance only while the cache is not stalled
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            begin
               o_s1_valid <= 1'b0;
               s2_valid   <= 1'b0;
            end
         else if (i_ce)
            begin
               o_s1_valid <= 1'b1;
               s2_valid   <= o_s1_valid;
            end
      end

   always_ff @(posedge clk)
      begin
         if (i_ce)
            begin
               s1_addr   <= i_addr;
               o_s2_addr <= s1_addr;   // Kept for replace and refill on a miss
            end
      end

   // Tag compare across the ways
   always_comb
      begin
         match_win = '0;
         for (int w = 0; w < NUM_WAYS; w++)
            begin
               hit_vec[w] = i_tags[w].valid &&
                            (i_tags[w].tag == s1_addr[ADDR_W-1 -: TAG_W]);
               if (hit_vec[w])
                  match_win = match_win | i_windows[w];
            end
      end

   assign o_hit = |hit_vec;

   // Requested window seen on its way into the RAM
   assign win_get = i_refilling & i_win_we &
                    (i_win_idx == o_s2_addr[P_WIN_BYTES +: WIN_IDX_W]);

   always_ff @(posedge clk)
      begin
         if (i_ce)
            o_ins <= match_win;
         else if (win_get)
            o_ins <= i_win;
      end

   assign o_valid = s2_valid & i_ce;    // Hidden while stalled

endmodule

`default_nettype wire

/* rtl/ic_refill.sv */
// Instruction cache line refill over the read-address/read-data bus with window assembly
`default_nettype none

module ic_refill
   import ic_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 i_rst_n,
   input  wire logic                 i_req,
   input  wire logic                 i_refilling,
   input  wire paddr_t               i_line_addr,
   input  wire logic                 i_arready,
   input  wire logic                 i_rvalid,
   input  wire logic [BUS_W-1:0]     i_rdata,
   input  wire logic                 i_rlast,
   output logic                      o_arvalid,
   output paddr_t                    o_araddr,
   output logic                      o_rready,
   output logic                      o_win_we,
   output logic [WIN_IDX_W-1:0]      o_win_idx,
   output win_t                      o_win,
   output logic                      o_done
);

   logic [BEAT_W-1:0] beat_cnt;
   logic [BUS_W-1:0]  lo_word;     // First beat of the current window
   logic              r_hs;

   // Address phase held until the slave takes it
   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            o_arvalid <= 1'b0;
         else if (i_req)
            o_arvalid <= 1'b1;
         else if (o_arvalid && i_arready)
            o_arvalid <= 1'b0;
      end

   always_ff @(posedge clk)
      begin
         if (i_req)
            o_araddr <= {i_line_addr[ADDR_W-1:P_LINE], {P_LINE{1'b0}}};
      end

   // No data accepted before the address is out
   assign o_rready = i_refilling & ~o_arvalid;
   assign r_hs     = i_rvalid & o_rready;

   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            beat_cnt <= '0;
         else if (r_hs)
            beat_cnt <= i_rlast ? '0 : beat_cnt + 1'b1;
      end

   // Even beats are the lower word of a window
   always_ff @(posedge clk)
      begin
         if (r_hs && !beat_cnt[0])
            lo_word <= i_rdata;
      end

   assign o_win_we  = r_hs & beat_cnt[0];
   assign o_win_idx = beat_cnt[BEAT_W-1 -: WIN_IDX_W];
   assign o_win     = {i_rdata, lo_word};
   assign o_done    = r_hs & i_rlast;

endmodule

`default_nettype wire

/* rtl/ic_ctrl.sv */
// Instruction cache control FSM with boot sweep, round-robin replacement and RAM port muxing
`default_nettype none

module ic_ctrl
   import ic_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  i_rst_n,
   input  wire logic                  i_inv_we,
   input  wire paddr_t                i_inv_addr,
   input  wire paddr_t                i_addr,
   input  wire logic                  i_s1_valid,
   input  wire logic                  i_hit,
   input  wire paddr_t                i_s2_addr,
   input  wire logic                  i_win_we,
   input  wire logic [WIN_IDX_W-1:0]  i_win_idx,
   input  wire logic                  i_refill_done,
   output logic                       o_stall,
   output logic                       o_tag_re,
   output way_vec_t                   o_tag_we,
   output set_t                       o_set,
   output tag_entry_t                 o_tag_wdata,
   output logic [PAY_AW-1:0]          o_pay_addr,
   output way_vec_t                   o_pay_we,
   output logic                       o_req,
   output logic                       o_refilling
);

   ic_state_t         state;
   ic_state_t         state_nxt;
   set_t              boot_cnt;
   way_vec_t          rr_way;       // Next way to replace
   way_vec_t          victim;
   logic              miss;
   logic              miss_pend;    // Miss seen together with an invalidate
   set_t              inv_set;
   logic [PAY_AW-1:0] last_rd;      // Stage-1 RAM address for the reload

   assign miss = i_s1_valid & ~i_hit;

   always_comb
      begin
         state_nxt = state;
         case (state)
            BOOT:
               if (boot_cnt == '1)
                  state_nxt = IDLE;
            IDLE:
               if (i_inv_we)
                  state_nxt = INVALIDATE;
               else if (miss)
                  state_nxt = REPLACE;
            REPLACE:
               state_nxt = REFILL;
            REFILL:
               if (i_refill_done)
                  state_nxt = RELOAD;
            INVALIDATE:
               state_nxt = miss_pend ? REPLACE : RELOAD;
            RELOAD:
               state_nxt = IDLE;
            default:
               state_nxt = IDLE;
         endcase
      end

   always_ff @(posedge clk or negedge i_rst_n)
      begin
         if (!i_rst_n)
            begin
               state     <= BOOT;
               boot_cnt  <= '0;
               rr_way    <= way_vec_t'(1);
               victim    <= '0;
               miss_pend <= 1'b0;
            end
         else
            begin
               state <= state_nxt;
               if (state == BOOT)
                  boot_cnt <= boot_cnt + 1'b1;
               if (state == REPLACE)
                  begin
                     rr_way <= {rr_way[NUM_WAYS-2:0], rr_way[NUM_WAYS-1]};
                     victim <= rr_way;   // Payload writes follow the tag write
                  end
               if (state == IDLE)
                  miss_pend <= i_inv_we & miss;
            end
      end

   always_ff @(posedge clk)
      begin
         if (state == IDLE && i_inv_we)
            inv_set <= i_inv_addr[P_LINE +: P_SETS];
         if (o_tag_re)
            last_rd <= o_pay_addr;
      end

   // Tag RAM address
   always_comb
      begin
         case (state)
            BOOT:       o_set = boot_cnt;
            INVALIDATE: o_set = inv_set;
            REPLACE:    o_set = i_s2_addr[P_LINE +: P_SETS];
            RELOAD:     o_set = last_rd[PAY_AW-1 -: P_SETS];
            default:    o_set = i_addr[P_LINE +: P_SETS];
         endcase
      end

   // Window RAM address
   always_comb
      begin
         case (state)
            REFILL:  o_pay_addr = {i_s2_addr[P_LINE +: P_SETS], i_win_idx};
            RELOAD:  o_pay_addr = last_rd;
            default: o_pay_addr = i_addr[P_WIN_BYTES +: PAY_AW];
         endcase
      end

   // Boot and invalidate write an empty entry
   always_comb
      begin
         o_tag_wdata = '0;
         if (state == REPLACE)
            begin
               o_tag_wdata.tag   = i_s2_addr[ADDR_W-1 -: TAG_W];
               o_tag_wdata.valid = 1'b1;
            end
      end

   assign o_tag_we = (state == BOOT || state == INVALIDATE) ? '1 :
                     (state == REPLACE)                     ? rr_way : '0;
   assign o_pay_we = (state == REFILL && i_win_we) ? victim : '0;

   assign o_stall     = (state != IDLE);
   assign o_tag_re    = ~o_stall | (state == RELOAD);
   assign o_req       = (state == REPLACE);
   assign o_refilling = (state == REFILL);

endmodule

`default_nettype wire

/* rtl/icache.sv */
// Two-way set-associative instruction cache top joining the RAMs, lookup, refill and control
`default_nettype none

module icache
   import ic_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              i_rst_n,
   input  wire paddr_t            i_addr,
   output logic                   o_stall,
   output logic                   o_valid,
   output win_t                   o_ins,
   input  wire logic              i_inv_we,
   input  wire paddr_t            i_inv_addr,
   output logic                   o_arvalid,
   input  wire logic              i_arready,
   output paddr_t                 o_araddr,
   input  wire logic              i_rvalid,
   output logic                   o_rready,
   input  wire logic [BUS_W-1:0]  i_rdata,
   input  wire logic              i_rlast
);

   logic                      s1_valid;
   logic                      hit;
   paddr_t                    s2_addr;
   logic                      tag_re;
   way_vec_t                  tag_we;
   set_t                      set;
   tag_entry_t                tag_wdata;
   logic [PAY_AW-1:0]         pay_addr;
   way_vec_t                  pay_we;
   logic                      req;
   logic                      refilling;
   logic                      win_we;
   logic [WIN_IDX_W-1:0]      win_idx;
   win_t                      win;
   logic                      refill_done;
   tag_entry_t [NUM_WAYS-1:0] tags;
   win_t [NUM_WAYS-1:0]       windows;

   for (genvar w = 0; w < NUM_WAYS; w++)
      begin : g_way
         ic_ram #(.data_t(tag_entry_t), .AW(P_SETS)) u_tag_ram
            (
               .clk     (clk),
               .i_re    (tag_re),
               .i_we    (tag_we[w]),
               .i_addr  (set),
               .i_wdata (tag_wdata),
               .o_rdata (tags[w])
            );

         // Window RAM shares the read enable with the tags
         ic_ram #(.data_t(win_t), .AW(PAY_AW)) u_pay_ram
            (
               .clk     (clk),
               .i_re    (tag_re),
               .i_we    (pay_we[w]),
               .i_addr  (pay_addr),
               .i_wdata (win),
               .o_rdata (windows[w])
            );
      end

   ic_ctrl u_ctrl
      (
         .clk           (clk),
         .i_rst_n       (i_rst_n),
         .i_inv_we      (i_inv_we),
         .i_inv_addr    (i_inv_addr),
         .i_addr        (i_addr),
         .i_s1_valid    (s1_valid),
         .i_hit         (hit),
         .i_s2_addr     (s2_addr),
         .i_win_we      (win_we),
         .i_win_idx     (win_idx),
         .i_refill_done (refill_done),
         .o_stall       (o_stall),
         .o_tag_re      (tag_re),
         .o_tag_we      (tag_we),
         .o_set         (set),
         .o_tag_wdata   (tag_wdata),
         .o_pay_addr    (pay_addr),
         .o_pay_we      (pay_we),
         .o_req         (req),
         .o_refilling   (refilling)
      );

   ic_lookup u_lookup
      (
         .clk         (clk),
         .i_rst_n     (i_rst_n),
         .i_ce        (~o_stall),
         .i_addr      (i_addr),
         .i_tags      (tags),
         .i_windows   (windows),
         .i_refilling (refilling),
         .i_win_we    (win_we),
         .i_win_idx   (win_idx),
         .i_win       (win),
         .o_s1_valid  (s1_valid),
         .o_hit       (hit),
         .o_s2_addr   (s2_addr),
         .o_ins       (o_ins),
         .o_valid     (o_valid)
      );

   ic_refill u_refill
      (
         .clk         (clk),
         .i_rst_n     (i_rst_n),
         .i_req       (req),
         .i_refilling (refilling),
         .i_line_addr (s2_addr),
         .i_arready   (i_arready),
         .i_rvalid    (i_rvalid),
         .i_rdata     (i_rdata),
         .i_rlast     (i_rlast),
         .o_arvalid   (o_arvalid),
         .o_araddr    (o_araddr),
         .o_rready    (o_rready),
         .o_win_we    (win_we),
         .o_win_idx   (win_idx),
         .o_win       (win),
         .o_done      (refill_done)
      );

endmodule

`default_nettype wire

/* testbench/icache_properties.sv */
// Bus and fetch output protocol assertions bound to the instruction cache top
`default_nettype none

module icache_properties
   import ic_pkg::*;
(
   input wire logic   clk,
   input wire logic   i_rst_n,
   input wire logic   o_stall,
   input wire logic   o_valid,
   input wire logic   o_arvalid,
   input wire logic   i_arready,
   input wire paddr_t o_araddr,
   input wire logic   o_rready
);

   int fail_cnt = 0;   // Failed assertion count

   // Address phase held until the slave takes it
   a_ar_hold : assert property (@(posedge clk) disable iff (!i_rst_n)
                  o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
      else
         begin
            fail_cnt++;
            $error("o_arvalid or o_araddr changed before i_arready");
         end

   a_valid_stall : assert property (@(posedge clk) disable iff (!i_rst_n)
                      !(o_valid && o_stall))
      else
         begin
            fail_cnt++;
            $error("o_valid high while o_stall is high");
         end

   a_r_after_ar : assert property (@(posedge clk) disable iff (!i_rst_n)
                     !(o_rready && o_arvalid))
      else
         begin
            fail_cnt++;
            $error("o_rready high while o_arvalid is still pending");
         end

endmodule

bind icache icache_properties u_props
   (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .o_stall   (o_stall),
      .o_valid   (o_valid),
      .o_arvalid (o_arvalid),
      .i_arready (i_arready),
      .o_araddr  (o_araddr),
      .o_rready  (o_rready)
   );

`default_nettype wire

/* testbench/tb_icache.sv */
// Testbench for the two-way instruction cache with a burst memory model and a stimulus table
`default_nettype none

module tb_icache
   import ic_pkg::*;
();

   typedef struct packed {
      logic   inv;       // Invalidate instead of fetch
      paddr_t addr;
      logic   refill;    // Bus request expected
   } step_t;

   logic             clk;
   logic             i_rst_n;
   paddr_t           i_addr;
   logic             o_stall;
   logic             o_valid;
   win_t             o_ins;
   logic             i_inv_we;
   paddr_t           i_inv_addr;
   logic             o_arvalid;
   logic             i_arready;
   paddr_t           o_araddr;
   logic             i_rvalid;
   logic             o_rready;
   logic [BUS_W-1:0] i_rdata;
   logic             i_rlast;

   int     ar_count;
   paddr_t last_araddr;
   int     timeout_cycles = 100;

   // Sets 3, 5 and 10 are used and three tags meet in set 3
   step_t steps [0:17] = '{
      '{1'b0, 16'h1230, 1'b1},   // Cold miss into way 0
      '{1'b0, 16'h1238, 1'b0},   // Other window of the line
      '{1'b0, 16'h1230, 1'b0},
      '{1'b0, 16'h4530, 1'b1},   // Second tag into way 1
      '{1'b0, 16'h1234, 1'b0},
      '{1'b0, 16'h7838, 1'b1},   // Third tag evicts 0x12
      '{1'b0, 16'h4538, 1'b0},
      '{1'b0, 16'h1230, 1'b1},   // Back in and evicts 0x45
      '{1'b0, 16'h7830, 1'b0},
      '{1'b0, 16'h20a0, 1'b1},
      '{1'b0, 16'h20a8, 1'b0},
      '{1'b0, 16'h5550, 1'b1},
      '{1'b1, 16'h20a0, 1'b0},   // Clear set 10
      '{1'b0, 16'h20a8, 1'b1},
      '{1'b0, 16'h5550, 1'b0},   // Set 5 untouched
      '{1'b1, 16'h0030, 1'b0},   // Clear set 3
      '{1'b0, 16'h7830, 1'b1},
      '{1'b0, 16'h5558, 1'b0}
   };

   icache i_dut (.*);

   initial
      begin
         clk = 1'b0;
         forever
            #20 clk = ~clk;
      end

   // Memory word at byte address a
   function automatic logic [BUS_W-1:0] mem_word(input paddr_t a);
      return {a, ~a};
   endfunction

   function automatic win_t window_at(input paddr_t a);
      paddr_t w;
      w = {a[ADDR_W-1:P_WIN_BYTES], {P_WIN_BYTES{1'b0}}};
      return {mem_word(w + 16'd4), mem_word(w)};
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected)
         abort_run($sformatf("error at %0t: %s is %h, expected %h",
                             $time, what, actual, expected));
   endtask

   task automatic wait_idle(input string what);
      int cycles;
      cycles = 0;
      while (o_stall)
         begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles)
               abort_run($sformatf("o_stall stayed high too long after %s", what));
         end
   endtask

   task automatic run_fetch(input paddr_t addr, input logic exp_refill);
      int   ar_before;
      logic stalled;
      ar_before = ar_count;
      i_addr    = addr;
      @(negedge clk);                 // Accepted
      @(negedge clk);                 // Output register loaded on a hit
      stalled = o_stall;
      wait_idle("a fetch");
      check_equal(64'(stalled), 64'(exp_refill), "stall after acceptance");
      check_equal(64'(o_valid), 64'd1, "o_valid");
      check_equal(64'(o_ins), 64'(window_at(addr)), "o_ins");
      check_equal(64'(ar_count - ar_before), 64'(exp_refill), "bus request count");
      if (exp_refill)
         check_equal(64'(last_araddr), 64'({addr[ADDR_W-1:P_LINE], {P_LINE{1'b0}}}),
                     "o_araddr");
   endtask

   task automatic run_invalidate(input paddr_t addr, input logic exp_refill);
      int ar_before;
      ar_before  = ar_count;
      i_inv_we   = 1'b1;
      i_inv_addr = addr;
      @(negedge clk);
      i_inv_we = 1'b0;
      check_equal(64'(o_stall), 64'd1, "o_stall during invalidate");
      wait_idle("an invalidate");
      check_equal(64'(ar_count - ar_before), 64'(exp_refill), "bus requests on invalidate");
   endtask

   // Serves one line burst with random idle gaps
   task automatic serve_line();
      paddr_t base;
      int     n;
      base = o_araddr;
      check_equal(64'(base[P_LINE-1:0]), 64'd0, "o_araddr line alignment");
      repeat ($urandom % 4) @(negedge clk);
      i_arready = 1'b1;
      @(negedge clk);
      i_arready   = 1'b0;
      ar_count    = ar_count + 1;
      last_araddr = base;
      for (int b = 0; b < BEATS; b++)
         begin
            repeat ($urandom % 4) @(negedge clk);
            i_rvalid = 1'b1;
            i_rdata  = mem_word(base + paddr_t'(4 * b));
            i_rlast  = (b == BEATS - 1);
            n = 0;
            while (!o_rready)
               begin
                  @(negedge clk);
                  n++;
                  if (n > timeout_cycles)
                     abort_run("o_rready never came up during the refill");
               end
            @(negedge clk);           // Beat taken on the rising edge before
            i_rvalid = 1'b0;
            i_rlast  = 1'b0;
         end
   endtask

   initial
      begin : bus_model
         void'($urandom(32'ha72b));
         i_arready   = 1'b0;
         i_rvalid    = 1'b0;
         i_rdata     = '0;
         i_rlast     = 1'b0;
         ar_count    = 0;
         last_araddr = '0;
         forever
            begin
               @(negedge clk);
               if (o_arvalid)
                  serve_line();
            end
      end

   initial
      begin
         i_rst_n    = 1'b0;
         i_addr     = steps[0].addr;  // First fetch goes out right after boot
         i_inv_we   = 1'b0;
         i_inv_addr = '0;
         repeat (8) @(negedge clk);
         i_rst_n = 1'b1;
         wait_idle("reset");
         check_equal(64'(ar_count), 64'd0, "bus requests during boot");
         for (int i = 0; i < $size(steps); i++)
            begin
               if (steps[i].inv)
                  run_invalidate(steps[i].addr, steps[i].refill);
               else
                  run_fetch(steps[i].addr, steps[i].refill);
            end
         if (i_dut.u_props.fail_cnt != 0)
            abort_run("protocol assertions failed during the run");
         else
            begin
               $display("Regression passed");
               $finish;
            end
      end

endmodule

`default_nettype wire

/* project.f */
rtl/ic_pkg.sv
rtl/ic_ram.sv
rtl/ic_lookup.sv
rtl/ic_refill.sv
rtl/ic_ctrl.sv
rtl/icache.sv
testbench/icache_properties.sv
testbench/tb_icache.sv

/* Makefile */
TOP = tb_icache
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
